/* common/id_stage_pkg.sv */
package id_stage_pkg;

    import mips_isa_pkg::*;

    // Operation codes seen by the execute stage
    typedef enum logic [7:0] {
        ALU_NOP   = 8'b00000000,
        ALU_AND   = 8'b00100100,
        ALU_OR    = 8'b00100101,
        ALU_XOR   = 8'b00100110,
        ALU_NOR   = 8'b00100111,
        ALU_SLL   = 8'b01111100,   // Also SLLV
        ALU_SRL   = 8'b00000010,   // Also SRLV
        ALU_SRA   = 8'b00000011,   // Also SRAV
        ALU_SLT   = 8'b00101010,
        ALU_SLTU  = 8'b00101011,
        ALU_ADD   = 8'b00100000,
        ALU_ADDU  = 8'b00100001,
        ALU_SUB   = 8'b00100010,
        ALU_SUBU  = 8'b00100011,
        ALU_ADDI  = 8'b01010101,
        ALU_ADDIU = 8'b01010110
    } alu_op_t;

    // Result group, one-hot apart from none
    typedef enum logic [2:0] {
        SEL_NONE  = 3'b000,
        SEL_LOGIC = 3'b001,
        SEL_SHIFT = 3'b010,
        SEL_ARITH = 3'b100
    } alu_sel_t;

    typedef enum logic [2:0] {
        IMM_NONE,
        IMM_ZERO_EXT,
        IMM_SIGN_EXT,
        IMM_UPPER,      // LUI
        IMM_SHAMT
    } imm_kind_t;

    typedef struct packed {
        alu_op_t   alu_op;
        alu_sel_t  alu_sel;
        logic      wr_en;
        reg_addr_t wr_addr;
    } ex_ctrl_t;

    typedef struct packed {
        logic      rd1_en;
        logic      rd2_en;
        reg_addr_t addr1;
        reg_addr_t addr2;
    } rf_read_t;

    // Result of one later stage, fed back for forwarding
    typedef struct packed {
        logic      en;
        reg_addr_t addr;
        word_t     data;
    } bypass_t;

endpackage

/* common/mips_isa_pkg.sv */
package mips_isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [4:0]  shamt_t;
    typedef logic [15:0] imm16_t;

    // Primary opcode field, ins[31:26]
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'b000000,
        OP_ADDI    = 6'b001000,
        OP_ADDIU   = 6'b001001,
        OP_SLTI    = 6'b001010,
        OP_SLTIU   = 6'b001011,
        OP_ANDI    = 6'b001100,
        OP_ORI     = 6'b001101,
        OP_XORI    = 6'b001110,
        OP_LUI     = 6'b001111
    } opcode_t;

    // Function field of SPECIAL, ins[5:0]
    typedef enum logic [5:0] {
        FN_SLL  = 6'b000000,
        FN_SRL  = 6'b000010,
        FN_SRA  = 6'b000011,
        FN_SLLV = 6'b000100,
        FN_SRLV = 6'b000110,
        FN_SRAV = 6'b000111,
        FN_ADD  = 6'b100000,
        FN_ADDU = 6'b100001,
        FN_SUB  = 6'b100010,
        FN_SUBU = 6'b100011,
        FN_AND  = 6'b100100,
        FN_OR   = 6'b100101,
        FN_XOR  = 6'b100110,
        FN_NOR  = 6'b100111,
        FN_SLT  = 6'b101010,
        FN_SLTU = 6'b101011
    } funct_t;

    // R-format view of an instruction word
    typedef struct packed {
        opcode_t   opcode;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;
        shamt_t    shamt;
        funct_t    funct;
    } instr_r_t;

    // I-format view
    typedef struct packed {
        opcode_t   opcode;
        reg_addr_t rs;
        reg_addr_t rt;
        imm16_t    imm;
    } instr_i_t;

endpackage

/* compile.f */
+incdir+verification
common/mips_isa_pkg.sv
common/id_stage_pkg.sv
id_stage/ins_decoder.sv
id_stage/imm_gen.sv
id_stage/operand_bypass.sv
id_stage/id_stage.sv
verification/tb_id_stage.sv

/* id_stage/id_stage.sv */
`timescale 1ns/1ps

module id_stage
    import mips_isa_pkg::*;
    import id_stage_pkg::*;
(
    input  logic     reset,
    input  word_t    ins,
    input  word_t    rf_data1,
    input  word_t    rf_data2,
    input  bypass_t  ex_bypass,
    input  bypass_t  mem_bypass,
    output rf_read_t rf_read,
    output ex_ctrl_t ex_ctrl,
    output word_t    src_data1,
    output word_t    src_data2
);

    imm_kind_t imm_kind;
    word_t     imm;

    ins_decoder u_decoder (
        .reset    (reset),
        .ins      (ins),
        .rf_read  (rf_read),
        .ex_ctrl  (ex_ctrl),
        .imm_kind (imm_kind)
    );

    imm_gen u_imm_gen (
        .reset    (reset),
        .ins      (ins),
        .imm_kind (imm_kind),
        .imm      (imm)
    );

    // rs side, takes shamt for immediate shifts
    operand_bypass u_src1 (
        .reset      (reset),
        .rd_en      (rf_read.rd1_en),
        .addr       (rf_read.addr1),
        .rf_data    (rf_data1),
        .ex_bypass  (ex_bypass),
        .mem_bypass (mem_bypass),
        .imm        (imm),
        .src_data   (src_data1)
    );

    // rt side, takes the immediate for I-format
    operand_bypass u_src2 (
        .reset      (reset),
        .rd_en      (rf_read.rd2_en),
        .addr       (rf_read.addr2),
        .rf_data    (rf_data2),
        .ex_bypass  (ex_bypass),
        .mem_bypass (mem_bypass),
        .imm        (imm),
        .src_data   (src_data2)
    );

endmodule

/* id_stage/imm_gen.sv */
`timescale 1ns/1ps

module imm_gen
    import mips_isa_pkg::*;
    import id_stage_pkg::*;
(
    input  logic      reset,
    input  word_t     ins,
    input  imm_kind_t imm_kind,
    output word_t     imm
);

    instr_i_t i_fields;
    instr_r_t r_fields;

    assign i_fields = ins;
    assign r_fields = ins;

    always_comb begin
        if (reset) begin
            imm = '0;
        end
        else begin
            case (imm_kind)
                IMM_ZERO_EXT: begin
                    imm = {16'd0, i_fields.imm};
                end
                IMM_SIGN_EXT: begin
                    imm = {{16{i_fields.imm[15]}}, i_fields.imm};
                end
                IMM_UPPER: begin
                    imm = {i_fields.imm, 16'd0};
                end
                IMM_SHAMT: begin
                    imm = {27'd0, r_fields.shamt};
                end
                default: begin
                    imm = '0;
                end
            endcase
        end
    end

endmodule

/* id_stage/ins_decoder.sv */
`timescale 1ns/1ps

module ins_decoder
    import mips_isa_pkg::*;
    import id_stage_pkg::*;
(
    input  logic      reset,
    input  word_t     ins,
    output rf_read_t  rf_read,
    output ex_ctrl_t  ex_ctrl,
    output imm_kind_t imm_kind
);

    instr_r_t  fields;
    alu_op_t   rr_op;
    alu_sel_t  rr_sel;
    logic      rr_hit;
    logic      shift_imm;
    alu_op_t   i_op;
    alu_sel_t  i_sel;
    imm_kind_t i_kind;
    logic      i_hit;

    assign fields = ins;

    // Function code to operation, shared by variable and immediate shifts
    always_comb begin
        case (fields.funct)
            FN_AND:  rr_op = ALU_AND;
            FN_OR:   rr_op = ALU_OR;
            FN_XOR:  rr_op = ALU_XOR;
            FN_NOR:  rr_op = ALU_NOR;
            FN_SLL:  rr_op = ALU_SLL;
            FN_SLLV: rr_op = ALU_SLL;
            FN_SRL:  rr_op = ALU_SRL;
            FN_SRLV: rr_op = ALU_SRL;
            FN_SRA:  rr_op = ALU_SRA;
            FN_SRAV: rr_op = ALU_SRA;
            FN_SLT:  rr_op = ALU_SLT;
            FN_SLTU: rr_op = ALU_SLTU;
            FN_ADD:  rr_op = ALU_ADD;
            FN_ADDU: rr_op = ALU_ADDU;
            FN_SUB:  rr_op = ALU_SUB;
            FN_SUBU: rr_op = ALU_SUBU;
            default: rr_op = ALU_NOP;
        endcase
    end

    // Group of register-register forms only
    always_comb begin
        case (fields.funct)
            FN_AND, FN_OR, FN_XOR, FN_NOR: begin
                rr_sel = SEL_LOGIC;
            end
            FN_SLLV, FN_SRLV, FN_SRAV: begin
                rr_sel = SEL_SHIFT;
            end
            FN_SLT, FN_SLTU, FN_ADD, FN_ADDU, FN_SUB, FN_SUBU: begin
                rr_sel = SEL_ARITH;
            end
            default: begin
                rr_sel = SEL_NONE;
            end
        endcase
    end

    assign rr_hit = (fields.opcode == OP_SPECIAL) && (fields.shamt == '0)
                    && (rr_sel != SEL_NONE);

    // SLL, SRL, SRA need opcode and rs all zero
    assign shift_imm = (ins[31:21] == 11'd0)
                       && (fields.funct inside {FN_SLL, FN_SRL, FN_SRA});

    always_comb begin
        i_hit  = 1'b1;
        i_op   = ALU_NOP;
        i_sel  = SEL_NONE;
        i_kind = IMM_NONE;
        case (fields.opcode)
            OP_ANDI, OP_ORI, OP_XORI: begin
                i_sel  = SEL_LOGIC;
                i_kind = IMM_ZERO_EXT;
                case (fields.opcode)
                    OP_ANDI: i_op = ALU_AND;
                    OP_ORI:  i_op = ALU_OR;
                    default: i_op = ALU_XOR;
                endcase
            end
            OP_LUI: begin
                i_op   = ALU_OR;   // OR with $rs against upper half
                i_sel  = SEL_LOGIC;
                i_kind = IMM_UPPER;
            end
            OP_SLTI, OP_SLTIU: begin
                i_op   = (fields.opcode == OP_SLTI) ? ALU_SLT : ALU_SLTU;
                i_sel  = SEL_ARITH;
                i_kind = IMM_SIGN_EXT;
            end
            OP_ADDI, OP_ADDIU: begin
                i_op   = (fields.opcode == OP_ADDI) ? ALU_ADDI : ALU_ADDIU;
                i_sel  = SEL_ARITH;
                i_kind = IMM_SIGN_EXT;
            end
            default: begin
                i_hit = 1'b0;
            end
        endcase
    end

    always_comb begin
        rf_read  = '0;
        ex_ctrl  = '0;
        imm_kind = IMM_NONE;
        if (!reset) begin
            rf_read.addr1   = fields.rs;
            rf_read.addr2   = fields.rt;
            ex_ctrl.wr_addr = fields.rd;
            if (shift_imm) begin
                rf_read.rd2_en  = 1'b1;   // Shift source is rt
                ex_ctrl.wr_en   = 1'b1;
                ex_ctrl.alu_op  = rr_op;
                ex_ctrl.alu_sel = SEL_SHIFT;
                imm_kind        = IMM_SHAMT;
            end
            else if (rr_hit) begin
                rf_read.rd1_en  = 1'b1;
                rf_read.rd2_en  = 1'b1;
                ex_ctrl.wr_en   = 1'b1;
                ex_ctrl.alu_op  = rr_op;
                ex_ctrl.alu_sel = rr_sel;
            end
            else if (i_hit) begin
                rf_read.rd1_en  = 1'b1;
                ex_ctrl.wr_en   = 1'b1;
                ex_ctrl.wr_addr = fields.rt;
                ex_ctrl.alu_op  = i_op;
                ex_ctrl.alu_sel = i_sel;
                imm_kind        = i_kind;
            end
        end
    end

endmodule

/* id_stage/operand_bypass.sv */
`timescale 1ns/1ps

module operand_bypass
    import mips_isa_pkg::*;
    import id_stage_pkg::*;
(
    input  logic      reset,
    input  logic      rd_en,
    input  reg_addr_t addr,
    input  word_t     rf_data,
    input  bypass_t   ex_bypass,
    input  bypass_t   mem_bypass,
    input  word_t     imm,
    output word_t     src_data
);

    logic ex_hit;
    logic mem_hit;

    // $0 is not filtered, the producer never writes it
    assign ex_hit  = ex_bypass.en && (ex_bypass.addr == addr);
    assign mem_hit = mem_bypass.en && (mem_bypass.addr == addr);

    always_comb begin
        if (reset) begin
            src_data = '0;
        end
        else if (!rd_en) begin
            src_data = imm;
        end
        else if (ex_hit) begin
            src_data = ex_bypass.data;    // Youngest result first
        end
        else if (mem_hit) begin
            src_data = mem_bypass.data;
        end
        else begin
            src_data = rf_data;
        end
    end

endmodule

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timescale 1ns/1ps -f compile.f --top-module tb_id_stage \
    -o sim_tb_id_stage

output=$(./obj_dir/sim_tb_id_stage 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "ALL CHECKS PASSED"; then
    exit 0
fi
exit 1

/* verification/id_ref_model.svh */
`ifndef ID_REF_MODEL_SVH
`define ID_REF_MODEL_SVH

// All DUT outputs for one input vector
typedef struct packed {
    rf_read_t rf;
    ex_ctrl_t ctrl;
    word_t    src1;
    word_t    src2;
} id_expect_t;

typedef struct packed {
    alu_op_t   op;
    alu_sel_t  sel;
    imm_kind_t kind;
} op_entry_t;

function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

// Register-register forms by function code
function automatic op_entry_t rr_entry(input logic [5:0] fn);
    case (fn)
        6'h24:   rr_entry = '{ALU_AND, SEL_LOGIC, IMM_NONE};
        6'h25:   rr_entry = '{ALU_OR, SEL_LOGIC, IMM_NONE};
        6'h26:   rr_entry = '{ALU_XOR, SEL_LOGIC, IMM_NONE};
        6'h27:   rr_entry = '{ALU_NOR, SEL_LOGIC, IMM_NONE};
        6'h04:   rr_entry = '{ALU_SLL, SEL_SHIFT, IMM_NONE};
        6'h06:   rr_entry = '{ALU_SRL, SEL_SHIFT, IMM_NONE};
        6'h07:   rr_entry = '{ALU_SRA, SEL_SHIFT, IMM_NONE};
        6'h2a:   rr_entry = '{ALU_SLT, SEL_ARITH, IMM_NONE};
        6'h2b:   rr_entry = '{ALU_SLTU, SEL_ARITH, IMM_NONE};
        6'h20:   rr_entry = '{ALU_ADD, SEL_ARITH, IMM_NONE};
        6'h21:   rr_entry = '{ALU_ADDU, SEL_ARITH, IMM_NONE};
        6'h22:   rr_entry = '{ALU_SUB, SEL_ARITH, IMM_NONE};
        6'h23:   rr_entry = '{ALU_SUBU, SEL_ARITH, IMM_NONE};
        default: rr_entry = '{ALU_NOP, SEL_NONE, IMM_NONE};
    endcase
endfunction

// I-format forms by opcode
function automatic op_entry_t i_entry(input logic [5:0] op);
    case (op)
        6'h0c:   i_entry = '{ALU_AND, SEL_LOGIC, IMM_ZERO_EXT};
        6'h0d:   i_entry = '{ALU_OR, SEL_LOGIC, IMM_ZERO_EXT};
        6'h0e:   i_entry = '{ALU_XOR, SEL_LOGIC, IMM_ZERO_EXT};
        6'h0f:   i_entry = '{ALU_OR, SEL_LOGIC, IMM_UPPER};
        6'h0a:   i_entry = '{ALU_SLT, SEL_ARITH, IMM_SIGN_EXT};
        6'h0b:   i_entry = '{ALU_SLTU, SEL_ARITH, IMM_SIGN_EXT};
        6'h08:   i_entry = '{ALU_ADDI, SEL_ARITH, IMM_SIGN_EXT};
        6'h09:   i_entry = '{ALU_ADDIU, SEL_ARITH, IMM_SIGN_EXT};
        default: i_entry = '{ALU_NOP, SEL_NONE, IMM_NONE};
    endcase
endfunction

function automatic word_t select_operand(
    input logic      en,
    input reg_addr_t addr,
    input word_t     rf_word,
    input bypass_t   exb,
    input bypass_t   memb,
    input word_t     imm
);
    if (!en) begin
        return imm;
    end
    if (exb.en && exb.addr == addr) begin
        return exb.data;
    end
    if (memb.en && memb.addr == addr) begin
        return memb.data;
    end
    return rf_word;
endfunction

function automatic id_expect_t ref_decode(
    input logic    rst,
    input word_t   i_word,
    input word_t   rf1,
    input word_t   rf2,
    input bypass_t exb,
    input bypass_t memb
);
    id_expect_t  e;
    op_entry_t   rr;
    op_entry_t   ie;
    logic [5:0]  op;
    logic [5:0]  fn;
    shamt_t      sh;
    logic [15:0] k;
    word_t       imm;
    e = '0;
    if (rst) begin
        return e;
    end
    op  = i_word[31:26];
    fn  = i_word[5:0];
    sh  = i_word[10:6];
    k   = i_word[15:0];
    imm = '0;
    rr  = rr_entry(fn);
    ie  = i_entry(op);
    e.rf.addr1     = i_word[25:21];
    e.rf.addr2     = i_word[20:16];
    e.ctrl.wr_addr = i_word[15:11];
    if (i_word[31:21] == 11'd0 && (fn == 6'h00 || fn == 6'h02 || fn == 6'h03)) begin
        e.rf.rd2_en    = 1'b1;
        e.ctrl.wr_en   = 1'b1;
        e.ctrl.alu_sel = SEL_SHIFT;
        case (fn)
            6'h00:   e.ctrl.alu_op = ALU_SLL;
            6'h02:   e.ctrl.alu_op = ALU_SRL;
            default: e.ctrl.alu_op = ALU_SRA;
        endcase
        imm = {27'd0, sh};    // Shift amount goes on operand 1
    end
    else if (op == 6'h00 && sh == 5'd0 && rr.sel != SEL_NONE) begin
        e.rf.rd1_en    = 1'b1;
        e.rf.rd2_en    = 1'b1;
        e.ctrl.wr_en   = 1'b1;
        e.ctrl.alu_op  = rr.op;
        e.ctrl.alu_sel = rr.sel;
    end
    else if (ie.sel != SEL_NONE) begin
        e.rf.rd1_en    = 1'b1;
        e.ctrl.wr_en   = 1'b1;
        e.ctrl.wr_addr = i_word[20:16];
        e.ctrl.alu_op  = ie.op;
        e.ctrl.alu_sel = ie.sel;
        case (ie.kind)
            IMM_ZERO_EXT: imm = {16'd0, k};
            IMM_UPPER:    imm = {k, 16'd0};
            default:      imm = {{16{k[15]}}, k};
        endcase
    end
    e.src1 = select_operand(e.rf.rd1_en, e.rf.addr1, rf1, exb, memb, imm);
    e.src2 = select_operand(e.rf.rd2_en, e.rf.addr2, rf2, exb, memb, imm);
    return e;
endfunction

task automatic check_read(input string name, input rf_read_t exp_v, input rf_read_t act_v);
    if (act_v !== exp_v) begin
        $display("mismatch %s rf_read expected %h actual %h", name, exp_v, act_v);
        report_failure();
    end
endtask

task automatic check_ctrl(input string name, input ex_ctrl_t exp_v, input ex_ctrl_t act_v);
    if (act_v !== exp_v) begin
        $display("mismatch %s ex_ctrl expected %h actual %h", name, exp_v, act_v);
        report_failure();
    end
endtask

task automatic check_word(
    input string name,
    input string port,
    input word_t exp_v,
    input word_t act_v
);
    if (act_v !== exp_v) begin
        $display("mismatch %s %s expected %h actual %h", name, port, exp_v, act_v);
        report_failure();
    end
endtask

`endif

/* verification/tb_id_stage.sv */
`timescale 1ns/1ps

module tb_id_stage
    import mips_isa_pkg::*;
    import id_stage_pkg::*;
();

    localparam int reset_cycles = 8;
    localparam int reset_vecs   = reset_cycles - 1;
    localparam int reps         = 4;
    localparam int unknown_reps = 2;
    localparam int num_vectors  = reset_vecs + 13 * reps + 8 * reps + 3 * reps
                                  + 4 * reps + 8 * unknown_reps;
    localparam int watchdog_ns  = num_vectors * 40 + reset_cycles * 20;

    logic     clk;
    logic     reset;
    word_t    ins;
    word_t    rf_data1;
    word_t    rf_data2;
    bypass_t  ex_bypass;
    bypass_t  mem_bypass;
    rf_read_t rf_read;
    ex_ctrl_t ex_ctrl;
    word_t    src_data1;
    word_t    src_data2;

    logic [31:0] rng_state;
    int          vec_count = 0;
    string       cur_test = "idle";

    funct_t  rr_functs[$] = '{FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLLV, FN_SRLV, FN_SRAV,
                              FN_SLT, FN_SLTU, FN_ADD, FN_ADDU, FN_SUB, FN_SUBU};
    opcode_t imm_ops[$] = '{OP_ANDI, OP_ORI, OP_XORI, OP_LUI,
                            OP_SLTI, OP_SLTIU, OP_ADDI, OP_ADDIU};
    funct_t  shift_functs[$] = '{FN_SLL, FN_SRL, FN_SRA};
    // MULT, MFHI, CLZ, ADD with shamt, opcode 63, MOVZ, SYNC, SLL with rs set
    word_t   unknown_words[$] = '{32'h0000_0018, 32'h0000_0010, 32'h7000_0020,
                                  32'h0000_00E0, 32'hFC00_0000, 32'h0000_000A,
                                  32'h0000_000F, 32'h0020_0000};

    `include "id_ref_model.svh"

    id_expect_t expect_v;

    id_stage UUT (
        .reset      (reset),
        .ins        (ins),
        .rf_data1   (rf_data1),
        .rf_data2   (rf_data2),
        .ex_bypass  (ex_bypass),
        .mem_bypass (mem_bypass),
        .rf_read    (rf_read),
        .ex_ctrl    (ex_ctrl),
        .src_data1  (src_data1),
        .src_data2  (src_data2)
    );

    task automatic report_failure();
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    function automatic word_t rand_word();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic bypass_t make_bypass(input logic en, input reg_addr_t addr,
                                            input word_t data);
        bypass_t b;
        b.en   = en;
        b.addr = addr;
        b.data = data;
        return b;
    endfunction

    function automatic bypass_t rand_bypass();
        word_t r;
        r = rand_word();
        return make_bypass(r[0], r[5:1], rand_word());
    endfunction

    function automatic bypass_t idle_bypass();
        word_t r;
        r = rand_word();
        return make_bypass(1'b0, r[5:1], rand_word());   // Never matches
    endfunction

    task automatic apply_vec(
        input string   name,
        input logic    rst,
        input word_t   i_word,
        input word_t   d1,
        input word_t   d2,
        input bypass_t eb,
        input bypass_t mb
    );
        @(negedge clk);
        cur_test   = name;
        reset      = rst;
        ins        = i_word;
        rf_data1   = d1;
        rf_data2   = d2;
        ex_bypass  = eb;
        mem_bypass = mb;
        vec_count  = vec_count + 1;
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        if (vec_count != 0) begin
            expect_v = ref_decode(reset, ins, rf_data1, rf_data2, ex_bypass, mem_bypass);
            check_read(cur_test, expect_v.rf, rf_read);
            check_ctrl(cur_test, expect_v.ctrl, ex_ctrl);
            check_word(cur_test, "src_data1", expect_v.src1, src_data1);
            check_word(cur_test, "src_data2", expect_v.src2, src_data2);
        end
    end

    initial begin
        #(watchdog_ns);
        $display("timeout: the run hung, stimulus not done after %0d ns", watchdog_ns);
        report_failure();
    end

    initial begin
        word_t     r;
        reg_addr_t rs;
        reg_addr_t rt;
        rng_state  = 32'd51;
        reset      = 1'b1;
        ins        = '0;
        rf_data1   = '0;
        rf_data2   = '0;
        ex_bypass  = '0;
        mem_bypass = '0;
        for (int n = 0; n < reset_vecs; n++) begin
            apply_vec("reset", 1'b1, rand_word(), rand_word(), rand_word(),
                      rand_bypass(), rand_bypass());
        end
        foreach (rr_functs[j]) begin
            for (int n = 0; n < reps; n++) begin
                r = rand_word();
                apply_vec("reg_reg", 1'b0, {6'd0, r[25:11], 5'd0, rr_functs[j]},
                          rand_word(), rand_word(), idle_bypass(), idle_bypass());
            end
        end
        foreach (imm_ops[j]) begin
            for (int n = 0; n < reps; n++) begin
                r = rand_word();
                apply_vec("immediate", 1'b0,
                          {imm_ops[j], r[25:16], r[15:0] | (n[0] ? 16'h8000 : 16'h0000)},
                          rand_word(), rand_word(), idle_bypass(), idle_bypass());
            end
        end
        foreach (shift_functs[j]) begin
            for (int n = 0; n < reps; n++) begin
                r = rand_word();
                apply_vec("shift_imm", 1'b0, {11'd0, r[20:6], shift_functs[j]},
                          rand_word(), rand_word(), idle_bypass(), idle_bypass());
            end
        end
        for (int n = 0; n < reps; n++) begin
            r  = rand_word();
            rs = r[25:21];
            rt = rs + 5'd1;
            apply_vec("bypass_both", 1'b0, {6'd0, rs, rt, r[15:11], 5'd0, FN_ADD},
                      rand_word(), rand_word(), make_bypass(1'b1, rs, rand_word()),
                      make_bypass(1'b1, rs, rand_word()));
            apply_vec("bypass_mem", 1'b0, {6'd0, rs, rt, r[15:11], 5'd0, FN_ADD},
                      rand_word(), rand_word(), make_bypass(1'b1, rs, rand_word()),
                      make_bypass(1'b1, rt, rand_word()));
            apply_vec("bypass_imm", 1'b0, {OP_ADDI, rs, rt, r[15:0]},
                      rand_word(), rand_word(), make_bypass(1'b1, rt, rand_word()),
                      make_bypass(1'b1, rt, rand_word()));
            apply_vec("bypass_shamt", 1'b0, {11'd0, rt, r[15:6], FN_SLL},
                      rand_word(), rand_word(), make_bypass(1'b1, 5'd0, rand_word()),
                      make_bypass(1'b1, rt, rand_word()));
        end
        foreach (unknown_words[j]) begin
            for (int n = 0; n < unknown_reps; n++) begin
                apply_vec("unknown", 1'b0, unknown_words[j] | (rand_word() & 32'h03FF_F800),
                          rand_word(), rand_word(), rand_bypass(), rand_bypass());
            end
        end
        @(negedge clk);
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule
